// File: hdl/video_defs.svh
/*
 * video back end constants
 * raster totals, sync and blanking limits, CPU register
 * addresses and colour table selects for the download port
 */

`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// ========================================
// raster geometry
`define H_TOTAL      384 // pixels per line
`define H_ACTIVE     256
`define H_SYNC_START 288
`define H_SYNC_END   320
`define V_TOTAL      264 // lines per frame
`define V_ACTIVE     224
`define V_SYNC_START 240
`define V_SYNC_END   244

// ========================================
// CPU register map
`define REG_HSCRL_LO 2'd0
`define REG_HSCRL_HI 2'd1 // only bit 0 used
`define REG_VSCRL    2'd2
`define REG_CTRL     2'd3 // bit 0 is screen flip

// colour table select, download address bits 9:8
`define PAL_RED   2'd0
`define PAL_GREEN 2'd1
`define PAL_BLUE  2'd2

`endif

// File: hdl/video_pkg.sv
/*
 * video types
 * coordinate, colour index and gun types, plus the layer pixel
 * byte seen either as a tile pixel or as a sprite pixel
 */

package video_pkg;

	typedef logic [8:0] hpos_t;       // 0..511 horizontal
	typedef logic [7:0] vpos_t;       // visible lines fit in a byte
	typedef logic [7:0] colour_idx_t;
	typedef logic [3:0] gun_t;        // one 4-bit colour gun

	// foreground tiles have four pens per palette
	typedef struct packed {
		logic [5:0] pal;
		logic [1:0] pen; // 0 is transparent
	} tile_pix_t;

	// sprites have sixteen pens per palette
	typedef struct packed {
		logic [3:0] pal;
		logic [3:0] pen; // 0 is transparent
	} sprite_pix_t;

	// same byte, two decodings
	typedef union packed {
		tile_pix_t   tile;
		sprite_pix_t sprite;
	} layer_pix_u;

endpackage

// File: hdl/raster_timing.sv
/*
 * raster timing
 * free running pixel and line counters, sync and blanking decode,
 * and raster coordinates mirrored while the screen is flipped
 */

`include "video_defs.svh"

module raster_timing
	import video_pkg::*;
(
	input  logic  pixel_clk,
	input  logic  RESET_n,
	input  logic  flip_i,
	output hpos_t raster_h_o,
	output vpos_t raster_v_o,
	output logic  hsync_o,
	output logic  vsync_o,
	output logic  hblank_o,
	output logic  vblank_o
);

	logic [8:0] h_cnt;
	logic [8:0] v_cnt; // needs 9 bits for 264 lines
	logic       h_wrap;
	logic       v_wrap;

	assign h_wrap = (h_cnt == 9'(`H_TOTAL - 1));
	assign v_wrap = (v_cnt == 9'(`V_TOTAL - 1));

	// ========================================
	// counters
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// line count steps once per line
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			v_cnt <= '0;
		end else if (h_wrap) begin
			if (v_wrap)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 9'd1;
		end
	end

	// ========================================
	// sync and blank, always from the true scan
	assign hsync_o  = (h_cnt >= 9'(`H_SYNC_START)) && (h_cnt < 9'(`H_SYNC_END));
	assign vsync_o  = (v_cnt >= 9'(`V_SYNC_START)) && (v_cnt < 9'(`V_SYNC_END));
	assign hblank_o = (h_cnt >= 9'(`H_ACTIVE));
	assign vblank_o = (v_cnt >= 9'(`V_ACTIVE));

	// board mirrors the scan by inverting the counts
	assign raster_h_o = flip_i ? ~h_cnt : h_cnt;
	assign raster_v_o = flip_i ? ~v_cnt[7:0] : v_cnt[7:0];

	// ========================================
	// checks

	// counters never escape their totals, whatever the flip history
	a_h_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		h_cnt < 9'(`H_TOTAL)
	) else $error("h count out of range");

	a_v_range: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		v_cnt < 9'(`V_TOTAL)
	) else $error("v count out of range");

endmodule

// File: hdl/scroll_regs.sv
/*
 * scroll and control registers
 * CPU write port open only in vertical blank, h/v scroll and flip
 * registers, and the scrolled background fetch coordinates
 */

`include "video_defs.svh"

module scroll_regs
	import video_pkg::*;
(
	input  logic       pixel_clk,
	input  logic       RESET_n,
	input  logic       vblank_i,
	input  logic       reg_valid_i,
	input  logic [1:0] reg_addr_i,
	input  logic [7:0] reg_data_i,
	input  hpos_t      raster_h_i,
	input  vpos_t      raster_v_i,
	output logic       reg_ready_o,
	output logic       flip_o,
	output hpos_t      bg_h_o,
	output vpos_t      bg_v_o
);

	hpos_t h_scroll; // split over two addresses
	vpos_t v_scroll;
	logic  flip_q;
	logic  reg_wr;

	// scroll never changes mid frame
	assign reg_ready_o = vblank_i;
	assign reg_wr      = reg_valid_i && reg_ready_o;

	// ========================================
	// register file
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_scroll <= '0;
			v_scroll <= '0;
			flip_q   <= 1'b0;
		end else if (reg_wr) begin
			case (reg_addr_i)
				`REG_HSCRL_LO: h_scroll[7:0] <= reg_data_i;
				`REG_HSCRL_HI: h_scroll[8]   <= reg_data_i[0];
				`REG_VSCRL:    v_scroll      <= reg_data_i;
				`REG_CTRL:     flip_q        <= reg_data_i[0];
				default: ;
			endcase
		end
	end

	assign flip_o = flip_q;

	// ========================================
	// background fetch position, wraps at 512 / 256
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			bg_h_o <= '0;
			bg_v_o <= '0;
		end else begin
			bg_h_o <= raster_h_i + h_scroll;
			bg_v_o <= raster_v_i + v_scroll;
		end
	end

	// a stalled write keeps its address and data until blank opens the port
	a_hold: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		(reg_valid_i && !reg_ready_o) |=> ($stable(reg_addr_i) && $stable(reg_data_i))
	) else $error("register write changed while waiting");

endmodule

// File: hdl/layer_priority.sv
/*
 * layer priority
 * foreground over sprites over background, by pen transparency,
 * registered into the colour index
 */

module layer_priority
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  layer_pix_u  fg_pix_i,
	input  layer_pix_u  sp_pix_i,
	input  colour_idx_t bg_pix_i,
	output colour_idx_t colour_idx_o
);

	colour_idx_t pick;
	logic        fg_opaque;
	logic        sp_opaque;

	// pen 0 lets the layer below show through
	assign fg_opaque = (fg_pix_i.tile.pen != 2'd0);
	assign sp_opaque = (sp_pix_i.sprite.pen != 4'd0);

	// ========================================
	// merge
	always_comb begin
		if (fg_opaque)
			pick = colour_idx_t'(fg_pix_i);   // whole byte, palette and pen
		else if (sp_opaque)
			pick = colour_idx_t'(sp_pix_i);
		else
			pick = bg_pix_i;                  // background is never transparent
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			colour_idx_o <= '0;
		else
			colour_idx_o <= pick;
	end

endmodule

// File: hdl/palette_rom.sv
/*
 * colour tables
 * red, green and blue 256-entry tables loaded through the download
 * port and read by the colour index into registered guns
 */

`include "video_defs.svh"

module palette_rom
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  colour_idx_t colour_idx_i,
	input  logic        dn_wr_i,
	input  logic [9:0]  dn_addr_i,
	input  gun_t        dn_data_i,
	output gun_t        red_o,
	output gun_t        green_o,
	output gun_t        blue_o
);

	localparam int NUM_TABLES = 3;

	gun_t        gun_q [NUM_TABLES];
	logic [1:0]  dn_sel;
	colour_idx_t dn_entry;

	assign dn_sel   = dn_addr_i[9:8]; // which table
	assign dn_entry = dn_addr_i[7:0];

	// ========================================
	// one table per gun
	for (genvar t = 0; t < NUM_TABLES; t++) begin : g_table
		gun_t mem [256];

		always_ff @(posedge pixel_clk) begin
			if (dn_wr_i && (dn_sel == 2'(t)))
				mem[dn_entry] <= dn_data_i;
		end

		// guns are black until the first pixel after reset
		always_ff @(posedge pixel_clk or negedge RESET_n) begin
			if (!RESET_n)
				gun_q[t] <= '0;
			else
				gun_q[t] <= mem[colour_idx_i];
		end
	end

	assign red_o   = gun_q[`PAL_RED];
	assign green_o = gun_q[`PAL_GREEN];
	assign blue_o  = gun_q[`PAL_BLUE];

	// select 3 has no table behind it
	a_dn_sel: assert property (
		@(posedge pixel_clk) disable iff (!RESET_n)
		dn_wr_i |-> (dn_sel != 2'd3)
	) else $error("download write to missing table");

endmodule

// File: hdl/video_core.sv
/*
 * video back end top level
 * raster timing, scroll registers, layer priority and colour tables
 * for the vertical shooter board
 */

module video_core
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	// CPU register writes
	input  logic        reg_valid_i,
	input  logic [1:0]  reg_addr_i,
	input  logic [7:0]  reg_data_i,
	output logic        reg_ready_o,
	// colour table download
	input  logic        dn_wr_i,
	input  logic [9:0]  dn_addr_i,
	input  gun_t        dn_data_i,
	// layer pixels
	input  layer_pix_u  fg_pix_i,
	input  layer_pix_u  sp_pix_i,
	input  colour_idx_t bg_pix_i,
	// coordinates to the layer generators
	output hpos_t       raster_h_o,
	output vpos_t       raster_v_o,
	output hpos_t       bg_h_o,
	output vpos_t       bg_v_o,
	// video out
	output gun_t        red_o,
	output gun_t        green_o,
	output gun_t        blue_o,
	output logic        hsync_o,
	output logic        vsync_o,
	output logic        hblank_o,
	output logic        vblank_o
);

	logic        flip;
	colour_idx_t colour_idx;

	raster_timing i_raster_timing (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.flip_i     (flip),
		.raster_h_o (raster_h_o),
		.raster_v_o (raster_v_o),
		.hsync_o    (hsync_o),
		.vsync_o    (vsync_o),
		.hblank_o   (hblank_o),
		.vblank_o   (vblank_o)
	);

	scroll_regs i_scroll_regs (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.vblank_i    (vblank_o), // write window
		.reg_valid_i (reg_valid_i),
		.reg_addr_i  (reg_addr_i),
		.reg_data_i  (reg_data_i),
		.raster_h_i  (raster_h_o),
		.raster_v_i  (raster_v_o),
		.reg_ready_o (reg_ready_o),
		.flip_o      (flip),
		.bg_h_o      (bg_h_o),
		.bg_v_o      (bg_v_o)
	);

	layer_priority i_layer_priority (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.fg_pix_i     (fg_pix_i),
		.sp_pix_i     (sp_pix_i),
		.bg_pix_i     (bg_pix_i),
		.colour_idx_o (colour_idx)
	);

	palette_rom i_palette_rom (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.colour_idx_i (colour_idx),
		.dn_wr_i      (dn_wr_i),
		.dn_addr_i    (dn_addr_i),
		.dn_data_i    (dn_data_i),
		.red_o        (red_o),
		.green_o      (green_o),
		.blue_o       (blue_o)
	);

endmodule

// File: verification/tb_video_core.sv
/*
 * testbench for the video back end
 * directed tests of raster timing, register write gating, scroll,
 * flip, and the colour tables behind the layer priority merge
 */

`include "video_defs.svh"

module tb_video_core
	import video_pkg::*;
();

	localparam int          FRAME     = `H_TOTAL * `V_TOTAL;
	localparam int          TIMEOUT   = 3 * FRAME + 2000; // tests take about two frames
	localparam int          PIX_COUNT = 256;
	localparam logic [31:0] SEED      = 32'hd6f4e9aa;

	logic        pixel_clk;
	logic        RESET_n;
	logic        reg_valid_i;
	logic [1:0]  reg_addr_i;
	logic [7:0]  reg_data_i;
	logic        reg_ready_o;
	logic        dn_wr_i;
	logic [9:0]  dn_addr_i;
	gun_t        dn_data_i;
	layer_pix_u  fg_pix_i;
	layer_pix_u  sp_pix_i;
	colour_idx_t bg_pix_i;
	hpos_t       raster_h_o;
	vpos_t       raster_v_o;
	hpos_t       bg_h_o;
	vpos_t       bg_v_o;
	gun_t        red_o;
	gun_t        green_o;
	gun_t        blue_o;
	logic        hsync_o;
	logic        vsync_o;
	logic        hblank_o;
	logic        vblank_o;

	int          cyc;        // cycles since reset release
	int          run_cycles; // all cycles, for the timeout
	logic [31:0] rng;

	video_core i_video_core (.*);

	always #2 pixel_clk = ~pixel_clk;

	always @(posedge pixel_clk) begin
		if (RESET_n)
			cyc <= cyc + 1;
	end

	always @(posedge pixel_clk) begin
		run_cycles <= run_cycles + 1;
		if (run_cycles >= TIMEOUT)
			report_failure($sformatf("timeout after %0d cycles, the tests stopped making progress",
				run_cycles));
	end

	// ========================================
	// helpers
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int col_of(input int k);
		return k % `H_TOTAL;
	endfunction

	function automatic int line_of(input int k);
		return (k / `H_TOTAL) % `V_TOTAL;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_hpos(input string name, input hpos_t exp, input hpos_t act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_vpos(input string name, input vpos_t exp, input vpos_t act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_idx_gun(input string name, input gun_t exp, input gun_t act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
	endtask

	// sync and blank follow the true scan position
	task automatic verify_sync_blank(input string tag, input int k);
		check_bit({tag, " hsync"},
			(col_of(k) >= `H_SYNC_START) && (col_of(k) < `H_SYNC_END), hsync_o);
		check_bit({tag, " vsync"},
			(line_of(k) >= `V_SYNC_START) && (line_of(k) < `V_SYNC_END), vsync_o);
		check_bit({tag, " hblank"}, col_of(k) >= `H_ACTIVE, hblank_o);
		check_bit({tag, " vblank"}, line_of(k) >= `V_ACTIVE, vblank_o);
	endtask

	task automatic reg_write(input logic [1:0] addr, input logic [7:0] data);
		@(posedge pixel_clk);
		reg_valid_i <= 1'b1;
		reg_addr_i  <= addr;
		reg_data_i  <= data;
		@(negedge pixel_clk);
		while (!reg_ready_o)
			@(negedge pixel_clk);
		@(posedge pixel_clk); // write lands on this edge
		reg_valid_i <= 1'b0;
	endtask

	// ========================================
	// tests
	task automatic reset_test();
		@(negedge pixel_clk);
		check_idx_gun("reset red", '0, red_o);
		check_idx_gun("reset green", '0, green_o);
		check_idx_gun("reset blue", '0, blue_o);
		check_hpos("reset raster_h", '0, raster_h_o);
		check_hpos("reset bg_h", '0, bg_h_o);
		check_bit("reset reg_ready", 1'b0, reg_ready_o);
		verify_sync_blank("reset", 0);
	endtask

	task automatic timing_test();
		int   k        = 0;
		int   last_hs  = -1;
		int   last_vs  = -1;
		int   vs_rises = 0;
		logic hs_prev  = 1'b0;
		logic vs_prev  = 1'b0;
		while (vs_rises < 2) begin
			@(negedge pixel_clk);
			k = cyc;
			check_hpos("timing raster_h", hpos_t'(col_of(k)), raster_h_o);
			check_vpos("timing raster_v", vpos_t'(line_of(k)), raster_v_o);
			verify_sync_blank("timing", k);
			if (hsync_o && !hs_prev) begin
				if (last_hs >= 0)
					check_count("timing hsync period", `H_TOTAL, k - last_hs);
				last_hs = k;
			end
			if (vsync_o && !vs_prev) begin
				if (last_vs >= 0)
					check_count("timing vsync period", FRAME, k - last_vs);
				last_vs  = k;
				vs_rises = vs_rises + 1;
			end
			hs_prev = hsync_o;
			vs_prev = vsync_o;
		end
	endtask

	// write raised at line 8, has to wait for blank
	task automatic write_gating_test();
		int    k       = 0;
		logic  written = 1'b0;
		vpos_t vs_exp  = '0;
		vpos_t held    = 8'h3c;
		repeat (8 * `H_TOTAL) @(posedge pixel_clk);
		reg_valid_i <= 1'b1;
		reg_addr_i  <= `REG_VSCRL;
		reg_data_i  <= held;
		while (k != FRAME - 1) begin
			@(negedge pixel_clk);
			k = cyc;
			check_bit("gating reg_ready", line_of(k) >= `V_ACTIVE, reg_ready_o);
			check_vpos("gating bg_v", vpos_t'(line_of(k - 1) + int'(vs_exp)), bg_v_o);
			if (written)
				vs_exp = held; // new scroll shows one sum later
			if (reg_valid_i && reg_ready_o) begin
				check_count("gating accept cycle", `V_ACTIVE * `H_TOTAL, k);
				written = 1'b1;
				@(posedge pixel_clk);
				reg_valid_i <= 1'b0;
			end
		end
	endtask

	task automatic scroll_test();
		int    k;
		hpos_t hs;
		vpos_t vs;
		rng = xorshift(rng);
		hs  = {1'b1, rng[7:0]}; // top bit set so the h sum wraps
		vs  = rng[15:8];
		reg_write(`REG_HSCRL_LO, hs[7:0]);
		reg_write(`REG_HSCRL_HI, {rng[22:16], hs[8]}); // upper bits ignored
		reg_write(`REG_VSCRL, vs);
		@(posedge pixel_clk);
		repeat (2 * `H_TOTAL) begin
			@(negedge pixel_clk);
			k = cyc;
			check_hpos("scroll bg_h", hpos_t'(col_of(k - 1) + int'(hs)), bg_h_o);
			check_vpos("scroll bg_v", vpos_t'(line_of(k - 1) + int'(vs)), bg_v_o);
		end
	endtask

	task automatic flip_test();
		int k;
		rng = xorshift(rng);
		reg_write(`REG_CTRL, {rng[6:0], 1'b1});
		repeat (2 * `H_TOTAL) begin
			@(negedge pixel_clk);
			k = cyc;
			check_hpos("flip raster_h", ~hpos_t'(col_of(k)), raster_h_o);
			check_vpos("flip raster_v", ~vpos_t'(line_of(k)), raster_v_o);
			verify_sync_blank("flip", k);
		end
	endtask

	task automatic palette_priority_test();
		gun_t        tab [3][256];
		colour_idx_t expect_q [$];
		colour_idx_t idx;
		colour_idx_t bg_byte;
		layer_pix_u  fg_v;
		layer_pix_u  sp_v;
		for (int t = 0; t < 3; t++) begin
			for (int e = 0; e < 256; e++) begin
				rng       = xorshift(rng);
				tab[t][e] = rng[3:0];
				@(posedge pixel_clk);
				dn_wr_i   <= 1'b1;
				dn_addr_i <= {2'(t), 8'(e)};
				dn_data_i <= rng[3:0];
			end
		end
		for (int n = 0; n < PIX_COUNT + 2; n++) begin
			@(posedge pixel_clk);
			dn_wr_i <= 1'b0;
			if (n < PIX_COUNT) begin
				rng     = xorshift(rng);
				fg_v    = rng[7:0];
				sp_v    = rng[15:8];
				bg_byte = rng[23:16];
				if (rng[24])
					fg_v.tile.pen = 2'd0;   // see through to sprites
				if (rng[25])
					sp_v.sprite.pen = 4'd0;
				fg_pix_i <= fg_v;
				sp_pix_i <= sp_v;
				bg_pix_i <= bg_byte;
				if (fg_v.tile.pen != 2'd0)
					idx = fg_v;
				else if (sp_v.sprite.pen != 4'd0)
					idx = sp_v;
				else
					idx = bg_byte;
				expect_q.push_back(idx);
			end
			@(negedge pixel_clk);
			if (n >= 2) begin // guns trail the pixels by two cycles
				idx = expect_q.pop_front();
				check_idx_gun("palette red", tab[`PAL_RED][idx], red_o);
				check_idx_gun("palette green", tab[`PAL_GREEN][idx], green_o);
				check_idx_gun("palette blue", tab[`PAL_BLUE][idx], blue_o);
			end
		end
	endtask

	// ========================================
	// sequence
	initial begin
		pixel_clk   = 1'b0;
		RESET_n     = 1'b0;
		reg_valid_i = 1'b0;
		reg_addr_i  = '0;
		reg_data_i  = '0;
		dn_wr_i     = 1'b0;
		dn_addr_i   = '0;
		dn_data_i   = '0;
		fg_pix_i    = '0;
		sp_pix_i    = '0;
		bg_pix_i    = '0;
		cyc         = 0;
		run_cycles  = 0;
		rng         = SEED;
		repeat (7) @(posedge pixel_clk);
		reset_test();
		@(posedge pixel_clk);
		RESET_n <= 1'b1;
		fork
			timing_test();
			write_gating_test();
		join
		scroll_test();  // still inside the second vertical blank
		flip_test();
		palette_priority_test();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: all.f
+incdir+hdl
hdl/video_pkg.sv
hdl/raster_timing.sv
hdl/scroll_regs.sv
hdl/layer_priority.sv
hdl/palette_rom.sv
hdl/video_core.sv
verification/tb_video_core.sv

// File: run.sh
#!/bin/sh
# build and run the video back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_video_core \
	-f all.f \
	-o tb_video_core

./obj_dir/tb_video_core
